// File: flist.f
hw/nic_rx_pkg.sv
hw/rx_ingress_csum.sv
hw/rx_buffer_writer.sv
hw/rx_packet_ram.sv
hw/nic_rx_path.sv
verification/tb_clock_gen.sv
verification/nic_rx_asserts.sv
verification/tb_nic_rx_path.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_nic_rx_path -f flist.f

sim_out=$(./obj_dir/Vtb_nic_rx_path 2>&1 || true)
echo "$sim_out"

if grep -qx "TEST OK" <<< "$sim_out"; then
    exit 0
else
    echo "Simulation did not report a pass"
    exit 1
fi

// File: verification/tb_nic_rx_path.sv
// Testbench top that runs random frames, truncation, a credit stall and slot readback on the receive path
`timescale 1ns/1ps

module tb_nic_rx_path;

    localparam int TIMEOUT     = 200;
    localparam int RAND_FRAMES = 23;
    localparam int MAX_WORDS   = 20;
    localparam int STALL_WAIT  = 20;

    typedef struct packed {
        logic [nic_rx_pkg::CSUM_W-1:0] csum;
        logic [nic_rx_pkg::LEN_W-1:0]  len;
        logic [nic_rx_pkg::SLOT_W-1:0] slot;
        nic_rx_pkg::cpl_status_t       status;
        logic                          lat_check;
    } exp_rec_t;

    logic                          clk;
    logic                          rst;
    logic [nic_rx_pkg::DATA_W-1:0] rx_data;
    logic [nic_rx_pkg::KEEP_W-1:0] rx_keep;
    logic                          rx_last;
    logic                          rx_valid;
    logic                          rx_ready;
    logic                          slot_credit;
    logic                          rd_en;
    logic [nic_rx_pkg::ADDR_W-1:0] rd_addr;
    logic [nic_rx_pkg::DATA_W-1:0] rd_data;
    logic                          cpl_valid;
    logic [nic_rx_pkg::SLOT_W-1:0] cpl_slot;
    logic [nic_rx_pkg::LEN_W-1:0]  cpl_len;
    logic [nic_rx_pkg::CSUM_W-1:0] cpl_csum;
    nic_rx_pkg::cpl_status_t       cpl_status;

    int                            seed = 32'ha55f_edea;
    int                            cycle_cnt = 0;
    int                            cpl_count = 0;
    int                            frames_sent = 0;
    logic [nic_rx_pkg::SLOT_W-1:0] next_slot = '0;
    exp_rec_t                      exp_q[$];
    int                            accept_q[$];
    logic [nic_rx_pkg::DATA_W-1:0] frame_buf [MAX_WORDS];
    // Host-side image of what each slot should hold
    logic [nic_rx_pkg::DATA_W-1:0] exp_mem [nic_rx_pkg::RAM_WORDS];
    int                            slot_words [nic_rx_pkg::NUM_SLOTS];
    logic [nic_rx_pkg::KEEP_W-1:0] slot_keep [nic_rx_pkg::NUM_SLOTS];

    tb_clock_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    nic_rx_path u_dut (
        .clk         (clk),
        .rst         (rst),
        .rx_data     (rx_data),
        .rx_keep     (rx_keep),
        .rx_last     (rx_last),
        .rx_valid    (rx_valid),
        .rx_ready    (rx_ready),
        .slot_credit (slot_credit),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .cpl_valid   (cpl_valid),
        .cpl_slot    (cpl_slot),
        .cpl_len     (cpl_len),
        .cpl_csum    (cpl_csum),
        .cpl_status  (cpl_status)
    );

    // Edge index that is read on falling edges where it is stable
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        stop_with_failure($sformatf("Error: time %0t, %s got 0x%0h, expected 0x%0h",
                                    $time, name, got, exp));
    endtask

    task automatic check_csum(input logic [nic_rx_pkg::CSUM_W-1:0] got,
                              input logic [nic_rx_pkg::CSUM_W-1:0] exp);
        if (got !== exp) report_value("cpl_csum", got, exp);
    endtask

    task automatic check_len(input logic [nic_rx_pkg::LEN_W-1:0] got,
                             input logic [nic_rx_pkg::LEN_W-1:0] exp);
        if (got !== exp) report_value("cpl_len", got, exp);
    endtask

    task automatic check_slot(input logic [nic_rx_pkg::SLOT_W-1:0] got,
                              input logic [nic_rx_pkg::SLOT_W-1:0] exp);
        if (got !== exp) report_value("cpl_slot", got, exp);
    endtask

    task automatic check_status(input nic_rx_pkg::cpl_status_t got,
                                input nic_rx_pkg::cpl_status_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Error: time %0t, cpl_status got %s, expected %s",
                                        $time, got.name(), exp.name()));
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) report_value("cpl_valid latency", got, exp);
    endtask

    // Only the enabled bytes of a final word are compared
    task automatic check_word(input logic [nic_rx_pkg::DATA_W-1:0] got,
                              input logic [nic_rx_pkg::DATA_W-1:0] exp,
                              input logic [nic_rx_pkg::KEEP_W-1:0] keep, input int addr);
        logic [nic_rx_pkg::DATA_W-1:0] mask;
        for (int b = 0; b < nic_rx_pkg::KEEP_W; b++) begin
            mask[8*b +: 8] = {8{keep[b]}};
        end
        if ((got & mask) !== (exp & mask)) begin
            report_value($sformatf("rd_data at address %0d", addr), got & mask, exp & mask);
        end
    endtask

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Expected record from the byte stream using big-endian pairs and end-around carry
    function automatic void ref_model(input int nwords, input logic [nic_rx_pkg::KEEP_W-1:0] keep,
                                      output logic [nic_rx_pkg::CSUM_W-1:0] csum,
                                      output logic [nic_rx_pkg::LEN_W-1:0] len,
                                      output nic_rx_pkg::cpl_status_t status);
        int unsigned sum;
        int          nbytes;
        logic [7:0]  b;
        sum    = 0;
        nbytes = 0;
        for (int w = 0; w < nwords; w++) begin
            for (int j = 0; j < nic_rx_pkg::KEEP_W; j++) begin
                if (w < nwords - 1 || keep[j]) begin
                    b = frame_buf[w][8*j +: 8];
                    if (nbytes % 2 == 0) begin
                        sum = sum + (32'(b) << 8);
                    end else begin
                        sum = sum + 32'(b);
                    end
                    nbytes++;
                end
            end
        end
        while (sum > 32'hffff) begin
            sum = (sum & 32'hffff) + (sum >> 16);
        end
        csum = nic_rx_pkg::CSUM_W'(sum);
        if (nwords > nic_rx_pkg::SLOT_WORDS) begin
            len    = nic_rx_pkg::LEN_W'(nic_rx_pkg::SLOT_WORDS * nic_rx_pkg::KEEP_W);
            status = nic_rx_pkg::CPL_TRUNC;
        end else begin
            len    = nic_rx_pkg::LEN_W'((nwords - 1) * nic_rx_pkg::KEEP_W + $countones(keep));
            status = nic_rx_pkg::CPL_OK;
        end
    endfunction

    task automatic fill_frame(input int nwords);
        for (int i = 0; i < nwords; i++) begin
            frame_buf[i] = $random(seed);
        end
    endtask

    task automatic send_frame(input int nwords, input logic [nic_rx_pkg::KEEP_W-1:0] keep,
                              input logic lat_check);
        exp_rec_t rec;
        int       stored;
        int       waited;
        ref_model(nwords, keep, rec.csum, rec.len, rec.status);
        rec.slot      = next_slot;
        rec.lat_check = lat_check;
        exp_q.push_back(rec);
        stored = (nwords > nic_rx_pkg::SLOT_WORDS) ? nic_rx_pkg::SLOT_WORDS : nwords;
        for (int i = 0; i < stored; i++) begin
            exp_mem[next_slot * nic_rx_pkg::SLOT_WORDS + i] = frame_buf[i];
        end
        slot_words[next_slot] = stored;
        slot_keep[next_slot]  = (nwords > nic_rx_pkg::SLOT_WORDS) ? '1 : keep;
        next_slot   = next_slot + 1'b1;
        frames_sent = frames_sent + 1;
        for (int i = 0; i < nwords; i++) begin
            @(negedge clk);
            rx_data  = frame_buf[i];
            rx_keep  = (i == nwords - 1) ? keep : '1;
            rx_last  = (i == nwords - 1);
            rx_valid = 1'b1;
            waited   = 0;
            while (!rx_ready) begin
                waited++;
                if (waited > TIMEOUT) stop_with_failure("Timeout: rx_ready never rose for a word");
                @(negedge clk);
            end
            // The word transfers on the next rising edge
            if (i == nwords - 1) accept_q.push_back(cycle_cnt + 1);
        end
        @(negedge clk);
        rx_valid = 1'b0;
        rx_last  = 1'b0;
    endtask

    task automatic wait_cpl(input int target);
        int waited;
        waited = 0;
        while (cpl_count < target) begin
            waited++;
            if (waited > TIMEOUT) stop_with_failure("Timeout: expected completion never came");
            @(posedge clk);
        end
    endtask

    task automatic read_slot(input int slot);
        int addr;
        for (int i = 0; i < slot_words[slot]; i++) begin
            addr = slot * nic_rx_pkg::SLOT_WORDS + i;
            @(negedge clk);
            rd_en   = 1'b1;
            rd_addr = nic_rx_pkg::ADDR_W'(addr);
            @(negedge clk);
            rd_en = 1'b0;
            check_word(rd_data, exp_mem[addr], (i == slot_words[slot] - 1) ? slot_keep[slot] : '1,
                       addr);
        end
    endtask

    task automatic return_credit();
        @(negedge clk);
        slot_credit = 1'b1;
        @(negedge clk);
        slot_credit = 1'b0;
    endtask

    // Send, wait, read back and free the slot, then idle a little
    task automatic run_one_frame(input int nwords);
        logic [nic_rx_pkg::SLOT_W-1:0] slot;
        logic [nic_rx_pkg::KEEP_W-1:0] keep;
        keep = nic_rx_pkg::KEEP_W'((1 << (rand_below(nic_rx_pkg::KEEP_W) + 1)) - 1);
        slot = next_slot;
        fill_frame(nwords);
        send_frame(nwords, keep, 1'b1);
        wait_cpl(frames_sent);
        read_slot(slot);
        return_credit();
        repeat (rand_below(4)) @(negedge clk);
    endtask

    // Completion checker
    initial begin : compare_proc
        exp_rec_t rec;
        int       idle;
        idle = 0;
        forever begin
            @(negedge clk);
            if (!rst && cpl_valid) begin
                if (exp_q.size() == 0 || accept_q.size() == 0) begin
                    stop_with_failure("Completion arrived with no frame outstanding");
                end
                rec = exp_q.pop_front();
                check_slot(cpl_slot, rec.slot);
                check_len(cpl_len, rec.len);
                check_csum(cpl_csum, rec.csum);
                check_status(cpl_status, rec.status);
                if (rec.lat_check) check_latency(cycle_cnt + 1 - accept_q[0], 2);
                void'(accept_q.pop_front());
                cpl_count = cpl_count + 1;
                idle = 0;
            end else if (exp_q.size() != 0) begin
                idle++;
                if (idle > TIMEOUT) stop_with_failure("Timeout: no completion for a sent frame");
            end
        end
    end

    initial begin : main_proc
        int waited;
        rx_data     = '0;
        rx_keep     = '0;
        rx_last     = 1'b0;
        rx_valid    = 1'b0;
        slot_credit = 1'b0;
        rd_en       = 1'b0;
        rd_addr     = '0;
        waited      = 0;
        while (rst !== 1'b0) begin
            waited++;
            if (waited > TIMEOUT) stop_with_failure("Timeout: reset was never released");
            @(negedge clk);
        end
        for (int f = 0; f < RAND_FRAMES; f++) begin
            run_one_frame(rand_below(nic_rx_pkg::SLOT_WORDS) + 1);
        end
        // Oversized frame lands in slot 3 and brings the slot pointer back to 0
        run_one_frame(MAX_WORDS);
        for (int f = 0; f < nic_rx_pkg::NUM_SLOTS; f++) begin
            fill_frame(nic_rx_pkg::SLOT_WORDS);
            send_frame(rand_below(nic_rx_pkg::SLOT_WORDS) + 1, '1, 1'b0);
        end
        fill_frame(4);
        fork
            send_frame(4, 4'b0111, 1'b0);
            begin
                repeat (STALL_WAIT) @(posedge clk);
                if (cpl_count != frames_sent - 1) begin
                    stop_with_failure("Frame without a free slot completed or others were lost");
                end
                @(negedge clk);
                if (rx_ready) report_value("rx_ready", 1, 0);
                slot_credit = 1'b1;
                @(negedge clk);
                slot_credit = 1'b0;
            end
        join
        wait_cpl(frames_sent);
        for (int s = 0; s < nic_rx_pkg::NUM_SLOTS; s++) begin
            read_slot(s);
        end
        for (int s = 0; s < nic_rx_pkg::NUM_SLOTS; s++) begin
            return_credit();
        end
        repeat (4) @(posedge clk);
        if (cpl_count == frames_sent && exp_q.size() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("Completion count %0d does not match %0d frames sent", cpl_count, frames_sent);
            $display("TEST FAILED");
            $fatal(1, "completion count mismatch");
        end
    end

endmodule

// File: verification/nic_rx_asserts.sv
// Concurrent protocol checks for the receive path, attached to the top level with bind
`timescale 1ns/1ps

module nic_rx_asserts (
    input logic                              clk,
    input logic                              rst,
    input logic                              cpl_valid,
    input logic                              ing_valid,
    input logic                              ing_ready,
    input logic [nic_rx_pkg::DATA_W-1:0]     ing_data,
    input logic [nic_rx_pkg::KEEP_W-1:0]     ing_keep,
    input logic                              ing_last,
    input logic [nic_rx_pkg::CREDIT_W-1:0]   credits
);

    // Completions stay quiet while reset is held
    cpl_quiet_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> !cpl_valid)
        else $error("cpl_valid went high while reset was held");

    // A stalled ingress word must not move or change
    ing_word_held: assert property (@(posedge clk) disable iff (rst)
        ing_valid && !ing_ready |=> ing_valid && $stable(ing_data) && $stable(ing_keep)
                                    && $stable(ing_last))
        else $error("ingress word changed or dropped before the writer accepted it");

    // Host returns never push the counter past the slot count
    credit_limit: assert property (@(posedge clk) disable iff (rst)
        credits <= nic_rx_pkg::NUM_SLOTS)
        else $error("free-slot counter exceeded the number of slots");

endmodule

bind nic_rx_path nic_rx_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .cpl_valid (cpl_valid),
    .ing_valid (ing_valid),
    .ing_ready (ing_ready),
    .ing_data  (ing_data),
    .ing_keep  (ing_keep),
    .ing_last  (ing_last),
    .credits   (u_writer.credits)
);

// File: verification/tb_clock_gen.sv
// Testbench clock and reset source, 100 ns clock with reset held for the first 10 cycles
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // Synchronous reset, released on a rising edge
    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: hw/nic_rx_path.sv
// Receive path top: ingress checksum stage, buffer writer and packet RAM
`timescale 1ns/1ps

module nic_rx_path (
    input  logic                              clk,
    input  logic                              rst,

    // Frame stream in
    input  logic [nic_rx_pkg::DATA_W-1:0]     rx_data,
    input  logic [nic_rx_pkg::KEEP_W-1:0]     rx_keep,
    input  logic                              rx_last,
    input  logic                              rx_valid,
    output logic                              rx_ready,

    // Host slot return
    input  logic                              slot_credit,

    // Host read port
    input  logic                              rd_en,
    input  logic [nic_rx_pkg::ADDR_W-1:0]     rd_addr,
    output logic [nic_rx_pkg::DATA_W-1:0]     rd_data,

    // Completion records
    output logic                              cpl_valid,
    output logic [nic_rx_pkg::SLOT_W-1:0]     cpl_slot,
    output logic [nic_rx_pkg::LEN_W-1:0]      cpl_len,
    output logic [nic_rx_pkg::CSUM_W-1:0]     cpl_csum,
    output nic_rx_pkg::cpl_status_t           cpl_status
);

    logic [nic_rx_pkg::DATA_W-1:0] ing_data;
    logic [nic_rx_pkg::KEEP_W-1:0] ing_keep;
    logic                          ing_last;
    logic [nic_rx_pkg::CSUM_W-1:0] ing_csum;
    logic                          ing_valid;
    logic                          ing_ready;

    logic                          wr_en;
    logic [nic_rx_pkg::ADDR_W-1:0] wr_addr;
    logic [nic_rx_pkg::DATA_W-1:0] wr_data;

    rx_ingress_csum u_ingress (
        .clk       (clk),
        .rst       (rst),
        .rx_data   (rx_data),
        .rx_keep   (rx_keep),
        .rx_last   (rx_last),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready),
        .ing_data  (ing_data),
        .ing_keep  (ing_keep),
        .ing_last  (ing_last),
        .ing_csum  (ing_csum),
        .ing_valid (ing_valid),
        .ing_ready (ing_ready)
    );

    rx_buffer_writer u_writer (
        .clk         (clk),
        .rst         (rst),
        .ing_data    (ing_data),
        .ing_keep    (ing_keep),
        .ing_last    (ing_last),
        .ing_csum    (ing_csum),
        .ing_valid   (ing_valid),
        .ing_ready   (ing_ready),
        .slot_credit (slot_credit),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .cpl_valid   (cpl_valid),
        .cpl_slot    (cpl_slot),
        .cpl_len     (cpl_len),
        .cpl_csum    (cpl_csum),
        .cpl_status  (cpl_status)
    );

    rx_packet_ram u_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// File: hw/rx_packet_ram.sv
// Simple dual-port packet buffer, written by the buffer writer and read by the host
`timescale 1ns/1ps

module rx_packet_ram (
    input  logic                              clk,
    input  logic                              wr_en,
    input  logic [nic_rx_pkg::ADDR_W-1:0]     wr_addr,
    input  logic [nic_rx_pkg::DATA_W-1:0]     wr_data,
    input  logic                              rd_en,
    input  logic [nic_rx_pkg::ADDR_W-1:0]     rd_addr,
    output logic [nic_rx_pkg::DATA_W-1:0]     rd_data
);

    // Slots laid out back to back, slot index in the high address bits
    logic [nic_rx_pkg::DATA_W-1:0] mem [nic_rx_pkg::RAM_WORDS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, data one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: hw/rx_buffer_writer.sv
// Second receive stage that holds slot credits, writes frames into packet RAM slots and issues completions
`timescale 1ns/1ps

module rx_buffer_writer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [nic_rx_pkg::DATA_W-1:0]     ing_data,
    input  logic [nic_rx_pkg::KEEP_W-1:0]     ing_keep,
    input  logic                              ing_last,
    input  logic [nic_rx_pkg::CSUM_W-1:0]     ing_csum,
    input  logic                              ing_valid,
    output logic                              ing_ready,
    input  logic                              slot_credit,
    output logic                              wr_en,
    output logic [nic_rx_pkg::ADDR_W-1:0]     wr_addr,
    output logic [nic_rx_pkg::DATA_W-1:0]     wr_data,
    output logic                              cpl_valid,
    output logic [nic_rx_pkg::SLOT_W-1:0]     cpl_slot,
    output logic [nic_rx_pkg::LEN_W-1:0]      cpl_len,
    output logic [nic_rx_pkg::CSUM_W-1:0]     cpl_csum,
    output nic_rx_pkg::cpl_status_t           cpl_status
);

    nic_rx_pkg::wr_state_t state;

    logic [nic_rx_pkg::CREDIT_W-1:0]                   credits;
    logic [nic_rx_pkg::SLOT_W-1:0]                     slot_ptr;
    logic [nic_rx_pkg::ADDR_W-nic_rx_pkg::SLOT_W-1:0]  word_idx;
    // Truncation flag, set once the slot has no room left
    logic                                              slot_full;
    logic [nic_rx_pkg::LEN_W-1:0]                      byte_cnt;
    logic [nic_rx_pkg::LEN_W-1:0]                      byte_next;
    logic                                              accept;
    logic                                              take_credit;

    // Number of enabled bytes in a word
    function automatic logic [nic_rx_pkg::LEN_W-1:0] keep_bytes(
        input logic [nic_rx_pkg::KEEP_W-1:0] keep
    );
        logic [nic_rx_pkg::LEN_W-1:0] n;
        n = '0;
        for (int i = 0; i < nic_rx_pkg::KEEP_W; i++) begin
            n = n + {{(nic_rx_pkg::LEN_W-1){1'b0}}, keep[i]};
        end
        return n;
    endfunction

    always_comb begin
        case (state)
            nic_rx_pkg::ST_WAIT_SLOT: ing_ready = (credits != '0);
            nic_rx_pkg::ST_WRITE:     ing_ready = 1'b1;
            default:                  ing_ready = 1'b0;
        endcase
    end

    assign accept      = ing_valid && ing_ready;
    assign take_credit = accept && (state == nic_rx_pkg::ST_WAIT_SLOT);

    // Words past the end of the slot are accepted but dropped
    assign wr_en   = accept && !slot_full;
    assign wr_addr = {slot_ptr, word_idx};
    assign wr_data = ing_data;

    // Bytes stored so far including the current word
    always_comb begin
        byte_next = byte_cnt;
        if (!slot_full) begin
            byte_next = byte_cnt + (ing_last ? keep_bytes(ing_keep)
                                             : nic_rx_pkg::LEN_W'(nic_rx_pkg::KEEP_W));
        end
    end

    // Credit taken by a new frame and returned by the host may coincide
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= nic_rx_pkg::CREDIT_W'(nic_rx_pkg::NUM_SLOTS);
        end else begin
            case ({take_credit, slot_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= nic_rx_pkg::ST_WAIT_SLOT;
            slot_ptr  <= '0;
            word_idx  <= '0;
            slot_full <= 1'b0;
            byte_cnt  <= '0;
            cpl_valid <= 1'b0;
        end else begin
            cpl_valid <= 1'b0;
            case (state)
                nic_rx_pkg::ST_WAIT_SLOT, nic_rx_pkg::ST_WRITE: begin
                    if (accept) begin
                        if (ing_last) begin
                            cpl_valid <= 1'b1;
                            slot_ptr  <= slot_ptr + 1'b1;
                            word_idx  <= '0;
                            slot_full <= 1'b0;
                            byte_cnt  <= '0;
                            state     <= nic_rx_pkg::ST_CPL;
                        end else begin
                            byte_cnt <= byte_next;
                            if (!slot_full) begin
                                word_idx <= word_idx + 1'b1;
                            end
                            // Slot depth is a power of two, so all ones marks the end
                            if (&word_idx) begin
                                slot_full <= 1'b1;
                            end
                            state <= nic_rx_pkg::ST_WRITE;
                        end
                    end
                end
                default: begin
                    state <= nic_rx_pkg::ST_WAIT_SLOT;
                end
            endcase
        end
    end

    // Completion record held for the cpl_valid pulse
    always_ff @(posedge clk) begin
        if (accept && ing_last) begin
            cpl_slot   <= slot_ptr;
            cpl_len    <= byte_next;
            cpl_csum   <= ing_csum;
            // A slot already full at the last word means words were dropped
            cpl_status <= slot_full ? nic_rx_pkg::CPL_TRUNC : nic_rx_pkg::CPL_OK;
        end
    end

endmodule

// File: hw/rx_ingress_csum.sv
// First receive stage: registers stream words and accumulates the per-frame checksum
`timescale 1ns/1ps

module rx_ingress_csum (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [nic_rx_pkg::DATA_W-1:0]     rx_data,
    input  logic [nic_rx_pkg::KEEP_W-1:0]     rx_keep,
    input  logic                              rx_last,
    input  logic                              rx_valid,
    output logic                              rx_ready,
    output logic [nic_rx_pkg::DATA_W-1:0]     ing_data,
    output logic [nic_rx_pkg::KEEP_W-1:0]     ing_keep,
    output logic                              ing_last,
    output logic [nic_rx_pkg::CSUM_W-1:0]     ing_csum,
    output logic                              ing_valid,
    input  logic                              ing_ready
);

    logic                          run_en;
    logic                          rx_fire;
    logic [nic_rx_pkg::CSUM_W-1:0] csum_acc;
    logic [nic_rx_pkg::CSUM_W-1:0] csum_next;
    logic [nic_rx_pkg::DATA_W-1:0] masked;

    // Ones' complement add with end-around carry
    function automatic logic [nic_rx_pkg::CSUM_W-1:0] ones_add(
        input logic [nic_rx_pkg::CSUM_W-1:0] a,
        input logic [nic_rx_pkg::CSUM_W-1:0] b
    );
        logic [nic_rx_pkg::CSUM_W:0] s;
        s = a + b;
        return s[nic_rx_pkg::CSUM_W-1:0] + {{(nic_rx_pkg::CSUM_W-1){1'b0}}, s[nic_rx_pkg::CSUM_W]};
    endfunction

    // Output register can take a new word when empty or when it moves on
    assign rx_fire  = rx_valid && rx_ready;
    assign rx_ready = run_en && (!ing_valid || ing_ready);

    // Keep only matters on the last word; disabled bytes count as zero
    always_comb begin
        for (int i = 0; i < nic_rx_pkg::KEEP_W; i++) begin
            masked[8*i +: 8] = (!rx_last || rx_keep[i]) ? rx_data[8*i +: 8] : 8'h00;
        end
    end

    // Byte 0 is the high half of each big-endian pair
    always_comb begin
        csum_next = csum_acc;
        for (int p = 0; p < nic_rx_pkg::KEEP_W / 2; p++) begin
            csum_next = ones_add(csum_next, {masked[16*p +: 8], masked[16*p+8 +: 8]});
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            run_en    <= 1'b0;
            ing_valid <= 1'b0;
            csum_acc  <= '0;
        end else begin
            run_en <= 1'b1;
            if (rx_fire) begin
                ing_valid <= 1'b1;
                // Restart the sum at each frame boundary
                csum_acc  <= rx_last ? '0 : csum_next;
            end else if (ing_ready) begin
                ing_valid <= 1'b0;
            end
        end
    end

    // Payload register, qualified by ing_valid
    always_ff @(posedge clk) begin
        if (rx_fire) begin
            ing_data <= rx_data;
            ing_keep <= rx_keep;
            ing_last <= rx_last;
            ing_csum <= csum_next;
        end
    end

endmodule

// File: hw/nic_rx_pkg.sv
// Shared sizes and enum types for the receive path, referenced as nic_rx_pkg::name
package nic_rx_pkg;

    // Stream word geometry
    localparam int DATA_W = 32;
    localparam int KEEP_W = DATA_W / 8;

    // Packet RAM layout, one fixed slot per frame
    localparam int NUM_SLOTS  = 4;
    localparam int SLOT_WORDS = 16;
    localparam int RAM_WORDS  = NUM_SLOTS * SLOT_WORDS;
    localparam int ADDR_W     = $clog2(RAM_WORDS);
    localparam int SLOT_W     = $clog2(NUM_SLOTS);

    // Completion record fields
    localparam int LEN_W  = 16;
    localparam int CSUM_W = 16;

    // Free-slot counter must be able to hold NUM_SLOTS itself
    localparam int CREDIT_W = $clog2(NUM_SLOTS + 1);

    // Buffer writer FSM
    typedef enum logic [1:0] {
        ST_WAIT_SLOT,
        ST_WRITE,
        ST_CPL
    } wr_state_t;

    // Completion status
    typedef enum logic [0:0] {
        CPL_OK,
        CPL_TRUNC
    } cpl_status_t;

endpackage
